// File: Makefile
TOP := tbDecodeStage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f decodeStage.f

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --top-module decodeStage -f decodeStage.f

clean:
	rm -rf obj_dir

// File: decodeStage.f
source/rv32iPkg.sv
source/idControl.sv
source/idRegfile.sv
source/branchGen.sv
source/decodeStage.sv
verification/tbDecodeStage.sv

// File: source/branchGen.sv
`timescale 1ns/1ps

module branchGen (
    input  rv32iPkg::branchOp_t branchOp_i,
    input  rv32iPkg::word_t     pc_i,
    input  rv32iPkg::word_t     rs1Data_i,
    input  rv32iPkg::word_t     imm_i,
    output rv32iPkg::word_t     pcDest_o
);

    rv32iPkg::word_t base;
    rv32iPkg::word_t sum;

    // JALR adds to rs1, everything else to the PC
    assign base = (branchOp_i == rv32iPkg::brRegRel) ? rs1Data_i : pc_i;
    assign sum  = base + imm_i;

    always_comb begin
        case (branchOp_i)
            rv32iPkg::brPcRel: begin
                pcDest_o = sum;
            end
            rv32iPkg::brRegRel: begin
                // JALR target has bit 0 forced low
                pcDest_o = {sum[31:1], 1'b0};
            end
            default: begin
                pcDest_o = '0;
            end
        endcase
    end

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
    parameter int regCount = 32
) (
    input                      Clk,
    input                      arstN_i,
    input  rv32iPkg::word_t    instrPc_i,
    input  rv32iPkg::word_t    instr_i,
    input                      stall_i,
    input                      flush_i,
    input  rv32iPkg::regAddr_t wbRdAddr_i,
    input  rv32iPkg::word_t    wbRdData_i,
    input                      wbRegWrEn_i,
    output rv32iPkg::idOut_t   idOut_o
);

    rv32iPkg::ctrl_t    ctrl;
    rv32iPkg::word_t    imm1;
    rv32iPkg::word_t    imm2;
    rv32iPkg::regAddr_t rdAddr;
    rv32iPkg::regAddr_t rs1Addr;
    rv32iPkg::regAddr_t rs2Addr;
    rv32iPkg::word_t    rs1Data;
    rv32iPkg::word_t    rs2Data;
    rv32iPkg::word_t    pcDest;
    rv32iPkg::idOut_t   idNext;

    // ==================================================
    // decode, register read, destination
    // ==================================================

    idControl idControl_inst (
        .instrPc_i (instrPc_i),
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .imm1_o    (imm1),
        .imm2_o    (imm2),
        .rdAddr_o  (rdAddr),
        .rs1Addr_o (rs1Addr),
        .rs2Addr_o (rs2Addr)
    );

    idRegfile #(
        .regCount (regCount)
    ) idRegfile_inst (
        .Clk       (Clk),
        .arstN_i   (arstN_i),
        .rs1Addr_i (rs1Addr),
        .rs2Addr_i (rs2Addr),
        .rdAddr_i  (wbRdAddr_i),
        .rdData_i  (wbRdData_i),
        .rdWrEn_i  (wbRegWrEn_i),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data)
    );

    branchGen branchGen_inst (
        .branchOp_i (ctrl.branchOp),
        .pc_i       (instrPc_i),
        .rs1Data_i  (rs1Data),
        .imm_i      (imm2),
        .pcDest_o   (pcDest)
    );

    always_comb begin
        idNext.pc      = instrPc_i;
        idNext.ctrl    = ctrl;
        idNext.pcDest  = pcDest;
        idNext.imm1    = imm1;
        idNext.imm2    = imm2;
        idNext.rs1Data = rs1Data;
        idNext.rs2Data = rs2Data;
        idNext.rdAddr  = rdAddr;
        idNext.rs1Addr = rs1Addr;
        idNext.rs2Addr = rs2Addr;
    end

    // ==================================================
    // ID/EX register
    // ==================================================

    // flush wins over stall
    always_ff @(posedge Clk or negedge arstN_i) begin
        if (!arstN_i) begin
            idOut_o <= '0;
        end else if (flush_i) begin
            idOut_o <= '0;
        end else if (stall_i) begin
            // bubble into execute, operands and addresses held
            idOut_o.ctrl.memWrEn  <= 1'b0;
            idOut_o.ctrl.memRdEn  <= 1'b0;
            idOut_o.ctrl.regWrEn  <= 1'b0;
            idOut_o.ctrl.memToReg <= 1'b0;
            idOut_o.ctrl.jump     <= 1'b0;
            idOut_o.ctrl.memOp    <= '0;
            idOut_o.rdAddr        <= '0;
        end else begin
            idOut_o <= idNext;
        end
    end

    // ==================================================
    // checks
    // ==================================================

    flushClearsCtrl: assert property (
        @(posedge Clk) disable iff (!arstN_i)
        flush_i |=> (idOut_o.ctrl == '0)
    ) else $error("controls not cleared after flush");

    // decoder must never ask for a load and a store at once
    noLoadAndStore: assert property (
        @(posedge Clk) disable iff (!arstN_i)
        !(ctrl.memWrEn && ctrl.memRdEn)
    ) else $error("memWrEn and memRdEn both set for instr %h", instr_i);

endmodule

// File: source/idControl.sv
`timescale 1ns/1ps

module idControl (
    input  rv32iPkg::word_t    instrPc_i,
    input  rv32iPkg::word_t    instr_i,
    output rv32iPkg::ctrl_t    ctrl_o,
    output rv32iPkg::word_t    imm1_o,
    output rv32iPkg::word_t    imm2_o,
    output rv32iPkg::regAddr_t rdAddr_o,
    output rv32iPkg::regAddr_t rs1Addr_o,
    output rv32iPkg::regAddr_t rs2Addr_o
);

    rv32iPkg::opcode_t  opcode;
    logic [2:0]         funct3;
    logic               funct7b5;
    rv32iPkg::regAddr_t rdField;
    rv32iPkg::regAddr_t rs1Field;
    rv32iPkg::regAddr_t rs2Field;
    rv32iPkg::word_t    immI;
    rv32iPkg::word_t    immS;
    rv32iPkg::word_t    immB;
    rv32iPkg::word_t    immU;
    rv32iPkg::word_t    immJ;

    // shared by OP and OPIMM, alt selects sub / sra
    function automatic rv32iPkg::aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
        rv32iPkg::aluOp_t op;
        case (f3)
            3'b000:  op = alt ? rv32iPkg::aluSub : rv32iPkg::aluAdd;
            3'b001:  op = rv32iPkg::aluSll;
            3'b010:  op = rv32iPkg::aluSlt;
            3'b011:  op = rv32iPkg::aluSltu;
            3'b100:  op = rv32iPkg::aluXor;
            3'b101:  op = alt ? rv32iPkg::aluSra : rv32iPkg::aluSrl;
            3'b110:  op = rv32iPkg::aluOr;
            default: op = rv32iPkg::aluAnd;
        endcase
        return op;
    endfunction

    // ==================================================
    // instruction fields
    // ==================================================

    assign opcode   = rv32iPkg::opcode_t'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];
    assign rdField  = instr_i[11:7];
    assign rs1Field = instr_i[19:15];
    assign rs2Field = instr_i[24:20];

    // sign-extended immediates, one per format
    assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
    assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
    assign immU = {instr_i[31:12], 12'b0};
    assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

    // ==================================================
    // decode
    // ==================================================

    always_comb begin
        // NOP unless an opcode below matches
        ctrl_o    = '0;
        imm1_o    = '0;
        imm2_o    = '0;
        rdAddr_o  = '0;
        rs1Addr_o = '0;
        rs2Addr_o = '0;

        case (opcode)
            rv32iPkg::opLui: begin
                // 0 + imm
                ctrl_o.aluSrcSel = 2'b11;
                ctrl_o.regWrEn   = 1'b1;
                imm2_o           = immU;
                rdAddr_o         = rdField;
            end
            rv32iPkg::opAuipc: begin
                ctrl_o.aluSrcSel = 2'b11;
                ctrl_o.regWrEn   = 1'b1;
                imm1_o           = instrPc_i;
                imm2_o           = immU;
                rdAddr_o         = rdField;
            end
            rv32iPkg::opJal: begin
                // link address built in execute from imm1
                ctrl_o.aluSrcSel = 2'b01;
                ctrl_o.branchOp  = rv32iPkg::brPcRel;
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.jump      = 1'b1;
                imm1_o           = instrPc_i;
                imm2_o           = immJ;
                rdAddr_o         = rdField;
            end
            rv32iPkg::opJalr: begin
                ctrl_o.aluSrcSel = 2'b01;
                ctrl_o.branchOp  = rv32iPkg::brRegRel;
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.jump      = 1'b1;
                imm1_o           = instrPc_i;
                imm2_o           = immI;
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
            end
            rv32iPkg::opBranch: begin
                // compare op: beq/bne sub, blt/bge slt, bltu/bgeu sltu
                case (funct3[2:1])
                    2'b00:   ctrl_o.aluOp = rv32iPkg::aluSub;
                    2'b11:   ctrl_o.aluOp = rv32iPkg::aluSltu;
                    default: ctrl_o.aluOp = rv32iPkg::aluSlt;
                endcase
                ctrl_o.branchOp   = rv32iPkg::brPcRel;
                ctrl_o.branchFlag = 1'b1;
                imm2_o            = immB;
                rs1Addr_o         = rs1Field;
                rs2Addr_o         = rs2Field;
            end
            rv32iPkg::opLoad: begin
                ctrl_o.aluSrcSel = 2'b10;
                ctrl_o.memRdEn   = 1'b1;
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.memToReg  = 1'b1;
                ctrl_o.memOp     = funct3;
                imm2_o           = immI;
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
            end
            rv32iPkg::opStore: begin
                ctrl_o.aluSrcSel = 2'b10;
                ctrl_o.memWrEn   = 1'b1;
                ctrl_o.memOp     = funct3;
                imm2_o           = immS;
                rs1Addr_o        = rs1Field;
                rs2Addr_o        = rs2Field;
            end
            rv32iPkg::opOpImm: begin
                // bit 30 is part of the immediate except for srai
                ctrl_o.aluSrcSel = 2'b10;
                ctrl_o.aluOp     = aluFromFunct3(funct3, funct7b5 && (funct3 == 3'b101));
                ctrl_o.regWrEn   = 1'b1;
                imm2_o           = immI;
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
            end
            rv32iPkg::opOp: begin
                ctrl_o.aluOp   = aluFromFunct3(funct3, funct7b5);
                ctrl_o.regWrEn = 1'b1;
                rdAddr_o       = rdField;
                rs1Addr_o      = rs1Field;
                rs2Addr_o      = rs2Field;
            end
            default: begin
                // FENCE, SYSTEM and illegal encodings stay a NOP
            end
        endcase
    end

endmodule

// File: source/idRegfile.sv
`timescale 1ns/1ps

module idRegfile #(
    parameter int regCount = 32
) (
    input                      Clk,
    input                      arstN_i,
    input  rv32iPkg::regAddr_t rs1Addr_i,
    input  rv32iPkg::regAddr_t rs2Addr_i,
    input  rv32iPkg::regAddr_t rdAddr_i,
    input  rv32iPkg::word_t    rdData_i,
    input                      rdWrEn_i,
    output rv32iPkg::word_t    rs1Data_o,
    output rv32iPkg::word_t    rs2Data_o
);

    rv32iPkg::word_t regs [regCount];

    // addresses past the end (RV32E) read as zero
    assign rs1Data_o = (32'(rs1Addr_i) < regCount) ? regs[rs1Addr_i] : '0;
    assign rs2Data_o = (32'(rs2Addr_i) < regCount) ? regs[rs2Addr_i] : '0;

    // writeback port, x0 is never written
    always_ff @(posedge Clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrEn_i && (rdAddr_i != '0) && (32'(rdAddr_i) < regCount)) begin
            regs[rdAddr_i] <= rdData_i;
        end
    end

    // x0 must survive any writeback sequence
    x0StaysZero: assert property (
        @(posedge Clk) disable iff (!arstN_i)
        regs[0] == '0
    ) else $error("regfile x0 holds %h", regs[0]);

endmodule

// File: source/rv32iPkg.sv
package rv32iPkg;

    // ==================================================
    // widths fixed by the ISA
    // ==================================================

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // funct3 of loads and stores, passed through to the memory stage
    typedef logic [2:0]  memOp_t;

    // ==================================================
    // encodings
    // ==================================================

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOp_t;

    // major opcodes handled by this stage, anything else decodes as a NOP
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcode_t;

    // base of the branch or jump destination
    typedef enum logic [1:0] {
        brNone   = 2'd0,
        brPcRel  = 2'd1,
        brRegRel = 2'd2
    } branchOp_t;

    // ==================================================
    // decoded controls and ID/EX contents
    // ==================================================

    typedef struct packed {
        // bit 0 picks imm1 for operand A, bit 1 picks imm2 for operand B
        logic [1:0] aluSrcSel;
        aluOp_t     aluOp;
        branchOp_t  branchOp;
        logic       branchFlag;
        logic       memWrEn;
        logic       memRdEn;
        logic       regWrEn;
        logic       memToReg;
        logic       jump;
        memOp_t     memOp;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        word_t    pcDest;
        word_t    imm1;
        word_t    imm2;
        word_t    rs1Data;
        word_t    rs2Data;
        regAddr_t rdAddr;
        regAddr_t rs1Addr;
        regAddr_t rs2Addr;
    } idOut_t;

endpackage

// File: verification/tbDecodeStage.sv
`timescale 1ns/1ps

module tbDecodeStage;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 2;
    // cycles per test in run order
    localparam int testCycles   = 4 + 10 + 10 + 6 + 6 + 8;
    localparam int marginCycles = 20;

    logic               Clk;
    logic               arstN;
    rv32iPkg::word_t    instrPc;
    rv32iPkg::word_t    instr;
    logic               stall;
    logic               flush;
    rv32iPkg::regAddr_t wbRdAddr;
    rv32iPkg::word_t    wbRdData;
    logic               wbRegWrEn;
    rv32iPkg::idOut_t   idOut;

    // expOut trails expNext by one edge like the DUT register
    rv32iPkg::idOut_t   expNext;
    rv32iPkg::idOut_t   expOut;
    rv32iPkg::word_t    shadow [32];
    int                 seed = 32'h66af;
    int                 errCount;
    int                 errAtStart;
    int                 passCount;
    int                 failCount;

    decodeStage #(
        .regCount (32)
    ) decodeStage_inst (
        .Clk         (Clk),
        .arstN_i     (arstN),
        .instrPc_i   (instrPc),
        .instr_i     (instr),
        .stall_i     (stall),
        .flush_i     (flush),
        .wbRdAddr_i  (wbRdAddr),
        .wbRdData_i  (wbRdData),
        .wbRegWrEn_i (wbRegWrEn),
        .idOut_o     (idOut)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    always @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            expOut <= '0;
        end else begin
            expOut <= expNext;
        end
    end

    // ==================================================
    // checks sampled at the falling edge
    // ==================================================

    task automatic fieldError(input string name, input logic [31:0] expVal,
            input logic [31:0] gotVal);
        $display("Error %s: expected %h, got %h at %0t", name, expVal, gotVal, $time);
        errCount++;
    endtask

    pcOk: assert property (@(negedge Clk) idOut.pc == expOut.pc)
        else fieldError("idOut_o.pc", expOut.pc, idOut.pc);
    ctrlOk: assert property (@(negedge Clk) idOut.ctrl == expOut.ctrl)
        else fieldError("idOut_o.ctrl", 32'(expOut.ctrl), 32'(idOut.ctrl));
    pcDestOk: assert property (@(negedge Clk) idOut.pcDest == expOut.pcDest)
        else fieldError("idOut_o.pcDest", expOut.pcDest, idOut.pcDest);
    imm1Ok: assert property (@(negedge Clk) idOut.imm1 == expOut.imm1)
        else fieldError("idOut_o.imm1", expOut.imm1, idOut.imm1);
    imm2Ok: assert property (@(negedge Clk) idOut.imm2 == expOut.imm2)
        else fieldError("idOut_o.imm2", expOut.imm2, idOut.imm2);
    rs1DataOk: assert property (@(negedge Clk) idOut.rs1Data == expOut.rs1Data)
        else fieldError("idOut_o.rs1Data", expOut.rs1Data, idOut.rs1Data);
    rs2DataOk: assert property (@(negedge Clk) idOut.rs2Data == expOut.rs2Data)
        else fieldError("idOut_o.rs2Data", expOut.rs2Data, idOut.rs2Data);
    rdAddrOk: assert property (@(negedge Clk) idOut.rdAddr == expOut.rdAddr)
        else fieldError("idOut_o.rdAddr", 32'(expOut.rdAddr), 32'(idOut.rdAddr));
    rs1AddrOk: assert property (@(negedge Clk) idOut.rs1Addr == expOut.rs1Addr)
        else fieldError("idOut_o.rs1Addr", 32'(expOut.rs1Addr), 32'(idOut.rs1Addr));
    rs2AddrOk: assert property (@(negedge Clk) idOut.rs2Addr == expOut.rs2Addr)
        else fieldError("idOut_o.rs2Addr", 32'(expOut.rs2Addr), 32'(idOut.rs2Addr));

    // ==================================================
    // encoders and expected values
    // ==================================================

    function automatic rv32iPkg::word_t rType(input logic [6:0] f7,
            input rv32iPkg::regAddr_t rs2, input rv32iPkg::regAddr_t rs1,
            input logic [2:0] f3, input rv32iPkg::regAddr_t rd, input rv32iPkg::opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv32iPkg::word_t iType(input logic [11:0] imm,
            input rv32iPkg::regAddr_t rs1, input logic [2:0] f3,
            input rv32iPkg::regAddr_t rd, input rv32iPkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32iPkg::word_t sType(input logic [11:0] imm,
            input rv32iPkg::regAddr_t rs2, input rv32iPkg::regAddr_t rs1,
            input logic [2:0] f3, input rv32iPkg::opcode_t op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic rv32iPkg::word_t bType(input logic [12:0] imm,
            input rv32iPkg::regAddr_t rs2, input rv32iPkg::regAddr_t rs1,
            input logic [2:0] f3, input rv32iPkg::opcode_t op);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
    endfunction

    function automatic rv32iPkg::word_t jType(input logic [20:0] imm,
            input rv32iPkg::regAddr_t rd, input rv32iPkg::opcode_t op);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
    endfunction

    // sign-extend the low bits of an immediate field
    function automatic rv32iPkg::word_t sext(input rv32iPkg::word_t value, input int bits);
        rv32iPkg::word_t shifted;
        shifted = value << (32 - bits);
        return rv32iPkg::word_t'($signed(shifted) >>> (32 - bits));
    endfunction

    // flag bits run from branchFlag down to jump in struct order
    function automatic rv32iPkg::ctrl_t controls(input logic [1:0] srcSel,
            input rv32iPkg::aluOp_t op, input rv32iPkg::branchOp_t br,
            input logic [5:0] flags, input logic [2:0] memOp);
        rv32iPkg::ctrl_t c;
        c.aluSrcSel = srcSel;
        c.aluOp     = op;
        c.branchOp  = br;
        {c.branchFlag, c.memWrEn, c.memRdEn, c.regWrEn, c.memToReg, c.jump} = flags;
        c.memOp     = memOp;
        return c;
    endfunction

    function automatic rv32iPkg::idOut_t expected(input rv32iPkg::word_t pc,
            input rv32iPkg::ctrl_t c, input rv32iPkg::word_t imm1, input rv32iPkg::word_t imm2,
            input rv32iPkg::regAddr_t rd, input rv32iPkg::regAddr_t rs1,
            input rv32iPkg::regAddr_t rs2);
        rv32iPkg::idOut_t e;
        e         = '0;
        e.pc      = pc;
        e.ctrl    = c;
        e.imm1    = imm1;
        e.imm2    = imm2;
        e.rdAddr  = rd;
        e.rs1Addr = rs1;
        e.rs2Addr = rs2;
        return e;
    endfunction

    // ==================================================
    // each stimulus task starts and ends on a falling edge
    // ==================================================

    task automatic issue(input rv32iPkg::word_t pc, input rv32iPkg::word_t word,
            input rv32iPkg::idOut_t exp);
        instrPc     = pc;
        instr       = word;
        stall       = 1'b0;
        flush       = 1'b0;
        wbRegWrEn   = 1'b0;
        // unused addresses are zero and x0 reads zero
        exp.rs1Data = shadow[exp.rs1Addr];
        exp.rs2Data = shadow[exp.rs2Addr];
        expNext     = exp;
        @(negedge Clk);
    endtask

    task automatic hold(input rv32iPkg::word_t pc, input rv32iPkg::word_t word,
            input logic doStall, input logic doFlush);
        instrPc   = pc;
        instr     = word;
        stall     = doStall;
        flush     = doFlush;
        wbRegWrEn = 1'b0;
        if (doFlush) begin
            expNext = '0;
        end else begin
            // bubble keeps operands and drops side effects
            expNext               = expOut;
            expNext.ctrl.memWrEn  = 1'b0;
            expNext.ctrl.memRdEn  = 1'b0;
            expNext.ctrl.regWrEn  = 1'b0;
            expNext.ctrl.memToReg = 1'b0;
            expNext.ctrl.jump     = 1'b0;
            expNext.ctrl.memOp    = '0;
            expNext.rdAddr        = '0;
        end
        @(negedge Clk);
    endtask

    task automatic writeReg(input rv32iPkg::regAddr_t addr, input rv32iPkg::word_t data);
        instrPc   = '0;
        instr     = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        wbRdAddr  = addr;
        wbRdData  = data;
        wbRegWrEn = 1'b1;
        expNext   = '0;
        @(negedge Clk);
        if (addr != '0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic reportTest(input string name);
        instrPc   = '0;
        instr     = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        wbRegWrEn = 1'b0;
        expNext   = '0;
        // half a cycle lets the last checks land
        @(posedge Clk);
        if (errCount == errAtStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d mismatches", name, errCount - errAtStart);
        end
        errAtStart = errCount;
        @(negedge Clk);
    endtask

    // ==================================================
    // tests
    // ==================================================

    task automatic decodeFormats();
        rv32iPkg::ctrl_t c;
        c = controls(2'b00, rv32iPkg::aluSub, rv32iPkg::brNone, 6'b000100, 3'b000);
        issue(32'h100, rType(7'h20, 5'd3, 5'd2, 3'b000, 5'd1, rv32iPkg::opOp),
              expected(32'h100, c, '0, '0, 5'd1, 5'd2, 5'd3));
        c.aluOp = rv32iPkg::aluSra;
        issue(32'h104, rType(7'h20, 5'd7, 5'd6, 3'b101, 5'd5, rv32iPkg::opOp),
              expected(32'h104, c, '0, '0, 5'd5, 5'd6, 5'd7));
        // addi -100
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b000100, 3'b000);
        issue(32'h108, iType(12'hf9c, 5'd4, 3'b000, 5'd8, rv32iPkg::opOpImm),
              expected(32'h108, c, '0, sext(32'hf9c, 12), 5'd8, 5'd4, 5'd0));
        c.aluOp = rv32iPkg::aluSra;
        issue(32'h10c, iType(12'h403, 5'd4, 3'b101, 5'd9, rv32iPkg::opOpImm),
              expected(32'h10c, c, '0, 32'h403, 5'd9, 5'd4, 5'd0));
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b001110, 3'b010);
        issue(32'h110, iType(12'h010, 5'd5, 3'b010, 5'd10, rv32iPkg::opLoad),
              expected(32'h110, c, '0, 32'h10, 5'd10, 5'd5, 5'd0));
        // sw at offset -4
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b010000, 3'b010);
        issue(32'h114, sType(12'hffc, 5'd11, 5'd10, 3'b010, rv32iPkg::opStore),
              expected(32'h114, c, '0, sext(32'hffc, 12), 5'd0, 5'd10, 5'd11));
        c = controls(2'b11, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b000100, 3'b000);
        issue(32'h118, {20'hdead0, 5'd12, rv32iPkg::opLui},
              expected(32'h118, c, '0, 32'hdead_0000, 5'd12, 5'd0, 5'd0));
        issue(32'h11c, {20'h80001, 5'd13, rv32iPkg::opAuipc},
              expected(32'h11c, c, 32'h11c, 32'h8000_1000, 5'd13, 5'd0, 5'd0));
    endtask

    task automatic regfileReadback();
        rv32iPkg::regAddr_t picks [4];
        rv32iPkg::ctrl_t    c;
        c = controls(2'b00, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b000100, 3'b000);
        for (int i = 0; i < 4; i++) begin
            picks[i] = rv32iPkg::regAddr_t'($random(seed));
            writeReg(picks[i], rv32iPkg::word_t'($random(seed)));
        end
        issue(32'h140, rType(7'h00, picks[1], picks[0], 3'b000, 5'd20, rv32iPkg::opOp),
              expected(32'h140, c, '0, '0, 5'd20, picks[0], picks[1]));
        issue(32'h144, rType(7'h00, picks[3], picks[2], 3'b000, 5'd21, rv32iPkg::opOp),
              expected(32'h144, c, '0, '0, 5'd21, picks[2], picks[3]));
        // x0 ignores the write
        writeReg(5'd0, 32'hffff_ffff);
        issue(32'h148, rType(7'h00, picks[0], 5'd0, 3'b000, 5'd22, rv32iPkg::opOp),
              expected(32'h148, c, '0, '0, 5'd22, 5'd0, picks[0]));
    endtask

    task automatic destinations();
        rv32iPkg::ctrl_t  c;
        rv32iPkg::idOut_t e;
        // bne back by 16
        c = controls(2'b00, rv32iPkg::aluSub, rv32iPkg::brPcRel, 6'b100000, 3'b000);
        e = expected(32'h400, c, '0, sext(32'h1ff0, 13), 5'd0, 5'd1, 5'd2);
        e.pcDest = 32'h400 + e.imm2;
        issue(32'h400, bType(13'h1ff0, 5'd2, 5'd1, 3'b001, rv32iPkg::opBranch), e);
        c = controls(2'b01, rv32iPkg::aluAdd, rv32iPkg::brPcRel, 6'b000101, 3'b000);
        e = expected(32'h404, c, 32'h404, 32'h800, 5'd1, 5'd0, 5'd0);
        e.pcDest = 32'h404 + 32'h800;
        issue(32'h404, jType(21'h000800, 5'd1, rv32iPkg::opJal), e);
        // even random base plus odd offset so bit 0 must drop
        writeReg(5'd7, rv32iPkg::word_t'($random(seed)) & 32'hffff_fffe);
        c.branchOp = rv32iPkg::brRegRel;
        e = expected(32'h408, c, 32'h408, sext(32'h801, 12), 5'd1, 5'd7, 5'd0);
        e.pcDest = (shadow[7] + e.imm2) & 32'hffff_fffe;
        issue(32'h408, iType(12'h801, 5'd7, 3'b000, 5'd1, rv32iPkg::opJalr), e);
    endtask

    task automatic stallHold();
        rv32iPkg::ctrl_t c;
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b001110, 3'b010);
        issue(32'h200, iType(12'h024, 5'd3, 3'b010, 5'd4, rv32iPkg::opLoad),
              expected(32'h200, c, '0, 32'h24, 5'd4, 5'd3, 5'd0));
        // store waits on the input while execute sees bubbles
        hold(32'h204, sType(12'h008, 5'd6, 5'd5, 3'b010, rv32iPkg::opStore), 1'b1, 1'b0);
        hold(32'h204, sType(12'h008, 5'd6, 5'd5, 3'b010, rv32iPkg::opStore), 1'b1, 1'b0);
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b010000, 3'b010);
        issue(32'h204, sType(12'h008, 5'd6, 5'd5, 3'b010, rv32iPkg::opStore),
              expected(32'h204, c, '0, 32'h8, 5'd0, 5'd5, 5'd6));
    endtask

    task automatic flushClear();
        rv32iPkg::ctrl_t c;
        c = controls(2'b00, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b000100, 3'b000);
        issue(32'h300, rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv32iPkg::opOp),
              expected(32'h300, c, '0, '0, 5'd3, 5'd1, 5'd2));
        hold(32'h304, rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv32iPkg::opOp), 1'b0, 1'b1);
        c = controls(2'b10, rv32iPkg::aluAdd, rv32iPkg::brNone, 6'b001110, 3'b010);
        issue(32'h308, iType(12'h004, 5'd1, 3'b010, 5'd2, rv32iPkg::opLoad),
              expected(32'h308, c, '0, 32'h4, 5'd2, 5'd1, 5'd0));
        // flush wins over stall
        hold(32'h30c, iType(12'h004, 5'd1, 3'b010, 5'd2, rv32iPkg::opLoad), 1'b1, 1'b1);
        // ecall and fence decode as a NOP
        issue(32'h310, 32'h0000_0073, expected(32'h310, '0, '0, '0, 5'd0, 5'd0, 5'd0));
        issue(32'h314, 32'h0000_000f, expected(32'h314, '0, '0, '0, 5'd0, 5'd0, 5'd0));
    endtask

    initial begin
        arstN      = 1'b0;
        instrPc    = '0;
        instr      = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        wbRdAddr   = '0;
        wbRdData   = '0;
        wbRegWrEn  = 1'b0;
        expNext    = '0;
        errCount   = 0;
        errAtStart = 0;
        passCount  = 0;
        failCount  = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(negedge Clk);
        arstN = 1'b1;
        // first edge after release still all zero
        issue(32'h0, 32'h0, '0);
        reportTest("reset");
        decodeFormats();
        reportTest("decode");
        regfileReadback();
        reportTest("regfile");
        destinations();
        reportTest("destinations");
        stallHold();
        reportTest("stall");
        flushClear();
        reportTest("flush");
        $display("%0d tests passed, %0d failed, %0d field errors",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #((resetCycles + testCycles + marginCycles) * clkPeriod);
        $display("run timed out at %0t before all tests finished", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
